//--- src/dual_pipe_params.svh
`ifndef DUAL_PIPE_PARAMS_SVH
`define DUAL_PIPE_PARAMS_SVH

`define DATA_WIDTH      32
`define INST_WIDTH      32
`define NUM_REGS        32
`define REG_ADDR_WIDTH  5
`define OPCODE_WIDTH    6
`define IMM_WIDTH       16
`define SHAMT_WIDTH     5

// instruction word fields
`define OPCODE_MSB      31
`define OPCODE_LSB      26
`define RS_MSB          25
`define RS_LSB          21
`define RT_MSB          20
`define RT_LSB          16
`define RD_MSB          15
`define RD_LSB          11
`define SHAMT_MSB       10
`define SHAMT_LSB       6
`define IMM_MSB         15
`define IMM_LSB         0

`endif

//--- src/dual_pipe_pkg.sv
`default_nettype none

`include "dual_pipe_params.svh"

package dual_pipe_pkg;

  // register forms write rd, immediate forms write rt
  typedef enum logic [`OPCODE_WIDTH-1:0] {
    op_nop  = 6'h00,
    op_add  = 6'h01,
    op_sub  = 6'h02,
    op_and  = 6'h03,
    op_or   = 6'h04,
    op_xor  = 6'h05,
    op_slt  = 6'h06,
    op_sll  = 6'h07,
    op_addi = 6'h08,
    op_ori  = 6'h09
  } opcode_e;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt,
    alu_sll
  } alu_op_e;

  // operand source, youngest producer first
  typedef enum logic [2:0] {
    fwd_reg,
    fwd_ex1,
    fwd_ex0,
    fwd_wb1,
    fwd_wb0
  } fwd_sel_e;

endpackage

`default_nettype wire

//--- src/issue_unit.sv
`timescale 1ns/10ps
`default_nettype none

`include "dual_pipe_params.svh"

module issue_unit
  import dual_pipe_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   req,
  input  logic                   pair_has1,
  input  logic [`INST_WIDTH-1:0] inst0,
  input  logic [`INST_WIDTH-1:0] inst1,
  output logic                   ack,
  output logic                   if_valid0,
  output logic                   if_valid1,
  output logic [`INST_WIDTH-1:0] if_inst0,
  output logic [`INST_WIDTH-1:0] if_inst1
);

  typedef enum logic [0:0] {
    st_idle,
    st_ack
  } state_e;

  state_e                      state;
  logic                        pending1;
  logic [`REG_ADDR_WIDTH-1:0]  dest0;
  logic                        dep;

  function automatic logic [`REG_ADDR_WIDTH-1:0] dest_of(input logic [`INST_WIDTH-1:0] inst);
    opcode_e op;
    op = opcode_e'(inst[`OPCODE_MSB:`OPCODE_LSB]);
    case (op)
      op_add, op_sub, op_and, op_or, op_xor, op_slt, op_sll: dest_of = inst[`RD_MSB:`RD_LSB];
      op_addi, op_ori: dest_of = inst[`RT_MSB:`RT_LSB];
      default: dest_of = '0;
    endcase
  endfunction

  function automatic logic reads_reg(input logic [`INST_WIDTH-1:0] inst,
                                     input logic [`REG_ADDR_WIDTH-1:0] addr);
    opcode_e                    op;
    logic [`REG_ADDR_WIDTH-1:0] rs;
    logic [`REG_ADDR_WIDTH-1:0] rt;
    op = opcode_e'(inst[`OPCODE_MSB:`OPCODE_LSB]);
    rs = inst[`RS_MSB:`RS_LSB];
    rt = inst[`RT_MSB:`RT_LSB];
    case (op)
      op_add, op_sub, op_and, op_or, op_xor, op_slt: reads_reg = (rs == addr) || (rt == addr);
      op_sll: reads_reg = (rt == addr);
      op_addi, op_ori: reads_reg = (rs == addr);
      default: reads_reg = 1'b0;
    endcase
  endfunction

  // inst1 needs inst0's result, so the pair gets split
  always_comb begin
    dest0 = dest_of(inst0);
    dep   = pair_has1 && (dest0 != '0) && reads_reg(inst1, dest0);
  end

  assign ack = (state == st_ack);

  ////////////////////////////////////////
  // four-phase intake

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= st_idle;
      pending1  <= 1'b0;
      if_valid0 <= 1'b0;
      if_valid1 <= 1'b0;
    end else begin
      if_valid0 <= 1'b0;
      if_valid1 <= 1'b0;
      case (state)
        st_idle: begin
          if (req && pending1) begin
            // second half of a split pair goes down lane 0
            if_valid0 <= 1'b1;
            pending1  <= 1'b0;
            state     <= st_ack;
          end else if (req) begin
            if_valid0 <= 1'b1;
            if (dep) begin
              pending1 <= 1'b1;
            end else begin
              if_valid1 <= pair_has1;
              state     <= st_ack;
            end
          end
        end
        st_ack: begin
          if (!req) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if_inst0 <= pending1 ? inst1 : inst0;
    if_inst1 <= inst1;
  end

endmodule

`default_nettype wire

//--- src/decode_lane.sv
`timescale 1ns/10ps
`default_nettype none

`include "dual_pipe_params.svh"

module decode_lane
  import dual_pipe_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       if_valid,
  input  logic [`INST_WIDTH-1:0]     if_inst,
  output logic [`REG_ADDR_WIDTH-1:0] rs_addr,
  output logic [`REG_ADDR_WIDTH-1:0] rt_addr,
  input  logic [`DATA_WIDTH-1:0]     rs_data,
  input  logic [`DATA_WIDTH-1:0]     rt_data,
  output logic                       id_valid,
  output alu_op_e                    id_alu_op,
  output logic [`REG_ADDR_WIDTH-1:0] id_rs,
  output logic [`REG_ADDR_WIDTH-1:0] id_rt,
  output logic [`DATA_WIDTH-1:0]     id_a,
  output logic [`DATA_WIDTH-1:0]     id_b,
  output logic [`IMM_WIDTH-1:0]      id_imm,
  output logic [`SHAMT_WIDTH-1:0]    id_shamt,
  output logic                       id_use_imm,
  output logic [`REG_ADDR_WIDTH-1:0] id_dest,
  output logic                       id_reg_write
);

  opcode_e                    opcode;
  logic [`REG_ADDR_WIDTH-1:0] rd_addr;
  alu_op_e                    alu_op;
  logic                       use_imm;
  logic                       writes;
  logic [`REG_ADDR_WIDTH-1:0] dest;

  assign opcode  = opcode_e'(if_inst[`OPCODE_MSB:`OPCODE_LSB]);
  assign rs_addr = if_inst[`RS_MSB:`RS_LSB];
  assign rt_addr = if_inst[`RT_MSB:`RT_LSB];
  assign rd_addr = if_inst[`RD_MSB:`RD_LSB];

  ////////////////////////////////////////
  // control decode

  always_comb begin
    alu_op  = alu_add;
    use_imm = 1'b0;
    writes  = 1'b1;
    dest    = rd_addr;
    case (opcode)
      op_add: alu_op = alu_add;
      op_sub: alu_op = alu_sub;
      op_and: alu_op = alu_and;
      op_or:  alu_op = alu_or;
      op_xor: alu_op = alu_xor;
      op_slt: alu_op = alu_slt;
      op_sll: alu_op = alu_sll;
      op_addi: begin
        use_imm = 1'b1;
        dest    = rt_addr;
      end
      op_ori: begin
        alu_op  = alu_or;
        use_imm = 1'b1;
        dest    = rt_addr;
      end
      // nop and anything unknown
      default: begin
        writes = 1'b0;
        dest   = '0;
      end
    endcase
  end

  ////////////////////////////////////////
  // ID/EX

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      id_valid     <= 1'b0;
      id_reg_write <= 1'b0;
    end else begin
      id_valid     <= if_valid;
      // writes to r0 are dropped here
      id_reg_write <= writes && (dest != '0);
    end
  end

  always_ff @(posedge clk) begin
    id_alu_op  <= alu_op;
    id_rs      <= rs_addr;
    id_rt      <= rt_addr;
    id_a       <= rs_data;
    id_b       <= rt_data;
    id_imm     <= if_inst[`IMM_MSB:`IMM_LSB];
    id_shamt   <= if_inst[`SHAMT_MSB:`SHAMT_LSB];
    id_use_imm <= use_imm;
    id_dest    <= dest;
  end

endmodule

`default_nettype wire

//--- src/register_file.sv
`timescale 1ns/10ps
`default_nettype none

`include "dual_pipe_params.svh"

module register_file (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [`REG_ADDR_WIDTH-1:0] raddr0,
  input  logic [`REG_ADDR_WIDTH-1:0] raddr1,
  input  logic [`REG_ADDR_WIDTH-1:0] raddr2,
  input  logic [`REG_ADDR_WIDTH-1:0] raddr3,
  output logic [`DATA_WIDTH-1:0]     rdata0,
  output logic [`DATA_WIDTH-1:0]     rdata1,
  output logic [`DATA_WIDTH-1:0]     rdata2,
  output logic [`DATA_WIDTH-1:0]     rdata3,
  input  logic                       we0,
  input  logic [`REG_ADDR_WIDTH-1:0] waddr0,
  input  logic [`DATA_WIDTH-1:0]     wdata0,
  input  logic                       we1,
  input  logic [`REG_ADDR_WIDTH-1:0] waddr1,
  input  logic [`DATA_WIDTH-1:0]     wdata1
);

  logic [`DATA_WIDTH-1:0] regs [`NUM_REGS];

  // write-through, port 1 is the younger write
  function automatic logic [`DATA_WIDTH-1:0] read_port(input logic [`REG_ADDR_WIDTH-1:0] addr);
    if (addr == '0) begin
      read_port = '0;
    end else if (we1 && (waddr1 == addr)) begin
      read_port = wdata1;
    end else if (we0 && (waddr0 == addr)) begin
      read_port = wdata0;
    end else begin
      read_port = regs[addr];
    end
  endfunction

  assign rdata0 = read_port(raddr0);
  assign rdata1 = read_port(raddr1);
  assign rdata2 = read_port(raddr2);
  assign rdata3 = read_port(raddr3);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (we0 && (waddr0 != '0)) begin
        regs[waddr0] <= wdata0;
      end
      // later assignment wins on a collision
      if (we1 && (waddr1 != '0)) begin
        regs[waddr1] <= wdata1;
      end
    end
  end

endmodule

`default_nettype wire

//--- src/execute_lane.sv
`timescale 1ns/10ps
`default_nettype none

`include "dual_pipe_params.svh"

module execute_lane
  import dual_pipe_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       id_valid,
  input  alu_op_e                    id_alu_op,
  input  logic [`REG_ADDR_WIDTH-1:0] id_rs,
  input  logic [`REG_ADDR_WIDTH-1:0] id_rt,
  input  logic [`DATA_WIDTH-1:0]     id_a,
  input  logic [`DATA_WIDTH-1:0]     id_b,
  input  logic [`IMM_WIDTH-1:0]      id_imm,
  input  logic [`SHAMT_WIDTH-1:0]    id_shamt,
  input  logic                       id_use_imm,
  input  logic [`REG_ADDR_WIDTH-1:0] id_dest,
  input  logic                       id_reg_write,
  input  logic                       ex_valid0,
  input  logic                       ex_valid1,
  input  logic [`REG_ADDR_WIDTH-1:0] ex_dest0,
  input  logic [`REG_ADDR_WIDTH-1:0] ex_dest1,
  input  logic [`DATA_WIDTH-1:0]     ex_result0,
  input  logic [`DATA_WIDTH-1:0]     ex_result1,
  output logic                       wb_valid,
  output logic [`REG_ADDR_WIDTH-1:0] wb_reg,
  output logic [`DATA_WIDTH-1:0]     wb_data
);

  fwd_sel_e               sel_a;
  fwd_sel_e               sel_b;
  logic [`DATA_WIDTH-1:0] op_a;
  logic [`DATA_WIDTH-1:0] op_b;
  logic [`DATA_WIDTH-1:0] alu_b;
  logic [`DATA_WIDTH-1:0] result;

  // lane 1 of EX/WB is younger than lane 0
  function automatic fwd_sel_e pick_src(input logic [`REG_ADDR_WIDTH-1:0] addr);
    if (addr == '0) begin
      pick_src = fwd_reg;
    end else if (ex_valid1 && (ex_dest1 == addr)) begin
      pick_src = fwd_ex1;
    end else if (ex_valid0 && (ex_dest0 == addr)) begin
      pick_src = fwd_ex0;
    end else begin
      pick_src = fwd_reg;
    end
  endfunction

  function automatic logic [`DATA_WIDTH-1:0] fwd_mux(input fwd_sel_e sel,
                                                      input logic [`DATA_WIDTH-1:0] reg_val);
    case (sel)
      fwd_ex1: fwd_mux = ex_result1;
      fwd_ex0: fwd_mux = ex_result0;
      default: fwd_mux = reg_val;
    endcase
  endfunction

  ////////////////////////////////////////
  // operands

  always_comb begin
    sel_a = pick_src(id_rs);
    sel_b = pick_src(id_rt);
    op_a  = fwd_mux(sel_a, id_a);
    op_b  = fwd_mux(sel_b, id_b);
    // immediates are zero-extended
    alu_b = id_use_imm ? {{(`DATA_WIDTH - `IMM_WIDTH){1'b0}}, id_imm} : op_b;
  end

  ////////////////////////////////////////
  // alu

  always_comb begin
    case (id_alu_op)
      alu_add: result = op_a + alu_b;
      alu_sub: result = op_a - alu_b;
      alu_and: result = op_a & alu_b;
      alu_or:  result = op_a | alu_b;
      alu_xor: result = op_a ^ alu_b;
      alu_slt: result = {{(`DATA_WIDTH - 1){1'b0}}, ($signed(op_a) < $signed(alu_b))};
      alu_sll: result = alu_b << id_shamt;
      default: result = '0;
    endcase
  end

  ////////////////////////////////////////
  // EX/WB

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wb_valid <= 1'b0;
    end else begin
      wb_valid <= id_valid && id_reg_write;
    end
  end

  always_ff @(posedge clk) begin
    wb_reg  <= id_dest;
    wb_data <= result;
  end

endmodule

`default_nettype wire

//--- src/dual_pipe_core.sv
`timescale 1ns/10ps
`default_nettype none

`include "dual_pipe_params.svh"

module dual_pipe_core
  import dual_pipe_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       req,
  input  logic                       pair_has1,
  input  logic [`INST_WIDTH-1:0]     inst0,
  input  logic [`INST_WIDTH-1:0]     inst1,
  output logic                       ack,
  output logic                       wb_valid0,
  output logic                       wb_valid1,
  output logic [`REG_ADDR_WIDTH-1:0] wb_reg0,
  output logic [`REG_ADDR_WIDTH-1:0] wb_reg1,
  output logic [`DATA_WIDTH-1:0]     wb_data0,
  output logic [`DATA_WIDTH-1:0]     wb_data1
);

  // IF/ID
  logic                       if_valid0, if_valid1;
  logic [`INST_WIDTH-1:0]     if_inst0, if_inst1;

  // register file reads
  logic [`REG_ADDR_WIDTH-1:0] rs_addr0, rt_addr0, rs_addr1, rt_addr1;
  logic [`DATA_WIDTH-1:0]     rs_data0, rt_data0, rs_data1, rt_data1;

  // ID/EX
  logic                       id_valid0, id_valid1;
  alu_op_e                    id_alu_op0, id_alu_op1;
  logic [`REG_ADDR_WIDTH-1:0] id_rs0, id_rs1, id_rt0, id_rt1;
  logic [`DATA_WIDTH-1:0]     id_a0, id_a1, id_b0, id_b1;
  logic [`IMM_WIDTH-1:0]      id_imm0, id_imm1;
  logic [`SHAMT_WIDTH-1:0]    id_shamt0, id_shamt1;
  logic                       id_use_imm0, id_use_imm1;
  logic [`REG_ADDR_WIDTH-1:0] id_dest0, id_dest1;
  logic                       id_reg_write0, id_reg_write1;

  issue_unit i_issue_unit (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (req),
    .pair_has1 (pair_has1),
    .inst0     (inst0),
    .inst1     (inst1),
    .ack       (ack),
    .if_valid0 (if_valid0),
    .if_valid1 (if_valid1),
    .if_inst0  (if_inst0),
    .if_inst1  (if_inst1)
  );

  // EX/WB of both lanes is the write side
  register_file i_register_file (
    .clk    (clk),
    .rst_n  (rst_n),
    .raddr0 (rs_addr0),
    .raddr1 (rt_addr0),
    .raddr2 (rs_addr1),
    .raddr3 (rt_addr1),
    .rdata0 (rs_data0),
    .rdata1 (rt_data0),
    .rdata2 (rs_data1),
    .rdata3 (rt_data1),
    .we0    (wb_valid0),
    .waddr0 (wb_reg0),
    .wdata0 (wb_data0),
    .we1    (wb_valid1),
    .waddr1 (wb_reg1),
    .wdata1 (wb_data1)
  );

  ////////////////////////////////////////
  // lane 0

  decode_lane i_decode_lane0 (
    .clk (clk), .rst_n (rst_n), .if_valid (if_valid0), .if_inst (if_inst0),
    .rs_addr (rs_addr0), .rt_addr (rt_addr0), .rs_data (rs_data0), .rt_data (rt_data0),
    .id_valid (id_valid0), .id_alu_op (id_alu_op0), .id_rs (id_rs0), .id_rt (id_rt0),
    .id_a (id_a0), .id_b (id_b0), .id_imm (id_imm0), .id_shamt (id_shamt0),
    .id_use_imm (id_use_imm0), .id_dest (id_dest0), .id_reg_write (id_reg_write0)
  );

  execute_lane i_execute_lane0 (
    .clk (clk), .rst_n (rst_n), .id_valid (id_valid0), .id_alu_op (id_alu_op0),
    .id_rs (id_rs0), .id_rt (id_rt0), .id_a (id_a0), .id_b (id_b0), .id_imm (id_imm0),
    .id_shamt (id_shamt0), .id_use_imm (id_use_imm0), .id_dest (id_dest0),
    .id_reg_write (id_reg_write0),
    .ex_valid0 (wb_valid0), .ex_valid1 (wb_valid1), .ex_dest0 (wb_reg0), .ex_dest1 (wb_reg1),
    .ex_result0 (wb_data0), .ex_result1 (wb_data1),
    .wb_valid (wb_valid0), .wb_reg (wb_reg0), .wb_data (wb_data0)
  );

  ////////////////////////////////////////
  // lane 1

  decode_lane i_decode_lane1 (
    .clk (clk), .rst_n (rst_n), .if_valid (if_valid1), .if_inst (if_inst1),
    .rs_addr (rs_addr1), .rt_addr (rt_addr1), .rs_data (rs_data1), .rt_data (rt_data1),
    .id_valid (id_valid1), .id_alu_op (id_alu_op1), .id_rs (id_rs1), .id_rt (id_rt1),
    .id_a (id_a1), .id_b (id_b1), .id_imm (id_imm1), .id_shamt (id_shamt1),
    .id_use_imm (id_use_imm1), .id_dest (id_dest1), .id_reg_write (id_reg_write1)
  );

  execute_lane i_execute_lane1 (
    .clk (clk), .rst_n (rst_n), .id_valid (id_valid1), .id_alu_op (id_alu_op1),
    .id_rs (id_rs1), .id_rt (id_rt1), .id_a (id_a1), .id_b (id_b1), .id_imm (id_imm1),
    .id_shamt (id_shamt1), .id_use_imm (id_use_imm1), .id_dest (id_dest1),
    .id_reg_write (id_reg_write1),
    .ex_valid0 (wb_valid0), .ex_valid1 (wb_valid1), .ex_dest0 (wb_reg0), .ex_dest1 (wb_reg1),
    .ex_result0 (wb_data0), .ex_result1 (wb_data1),
    .wb_valid (wb_valid1), .wb_reg (wb_reg1), .wb_data (wb_data1)
  );

endmodule

`default_nettype wire

//--- verification/dual_pipe_checker.sv
`timescale 1ns/10ps
`default_nettype none

`include "dual_pipe_params.svh"

module dual_pipe_checker (
  input logic                       clk,
  input logic                       rst_n,
  input logic                       req,
  input logic                       ack,
  input logic                       wb_valid0,
  input logic                       wb_valid1,
  input logic [`REG_ADDR_WIDTH-1:0] wb_reg0,
  input logic [`REG_ADDR_WIDTH-1:0] wb_reg1
);

  // failed assertions so far
  int fail_count = 0;

  ////////////////////////////////////////
  // four-phase handshake

  ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(ack) |-> $past(req))
    else begin
      $error("ack rose while req was low");
      fail_count++;
    end

  req_held: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(req) |-> ack)
    else begin
      $error("req dropped before ack");
      fail_count++;
    end

  ack_release: assert property (@(posedge clk) disable iff (!rst_n)
    (ack && !req) |=> !ack)
    else begin
      $error("ack stayed high after req dropped");
      fail_count++;
    end

  ////////////////////////////////////////
  // reset and writeback ports

  reset_quiet: assert property (@(posedge clk)
    !rst_n |=> (rst_n || (!ack && !wb_valid0 && !wb_valid1)))
    else begin
      $error("ack or writeback active during reset");
      fail_count++;
    end

  no_r0_lane0: assert property (@(posedge clk) disable iff (!rst_n)
    wb_valid0 |-> (wb_reg0 != '0))
    else begin
      $error("lane 0 wrote back to r0");
      fail_count++;
    end

  no_r0_lane1: assert property (@(posedge clk) disable iff (!rst_n)
    wb_valid1 |-> (wb_reg1 != '0))
    else begin
      $error("lane 1 wrote back to r0");
      fail_count++;
    end

endmodule

bind dual_pipe_core dual_pipe_checker i_dual_pipe_checker (
  .clk       (clk),
  .rst_n     (rst_n),
  .req       (req),
  .ack       (ack),
  .wb_valid0 (wb_valid0),
  .wb_valid1 (wb_valid1),
  .wb_reg0   (wb_reg0),
  .wb_reg1   (wb_reg1)
);

`default_nettype wire

//--- verification/dual_pipe_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "dual_pipe_params.svh"

module dual_pipe_tb
  import dual_pipe_pkg::*;
();

  localparam int clk_period   = 4;
  localparam int reset_cycles = 8;
  localparam int drive_delay  = 1;

  logic                       clk;
  logic                       rst_n;
  logic                       req;
  logic                       pair_has1;
  logic [`INST_WIDTH-1:0]     inst0;
  logic [`INST_WIDTH-1:0]     inst1;
  logic                       ack;
  logic                       wb_valid0;
  logic                       wb_valid1;
  logic [`REG_ADDR_WIDTH-1:0] wb_reg0;
  logic [`REG_ADDR_WIDTH-1:0] wb_reg1;
  logic [`DATA_WIDTH-1:0]     wb_data0;
  logic [`DATA_WIDTH-1:0]     wb_data1;

  // case file contents
  string                      test_names[$];
  int                         test_pair_count[$];
  int                         test_wb_count[$];
  logic [`INST_WIDTH-1:0]     pair_inst0[$];
  logic [`INST_WIDTH-1:0]     pair_inst1[$];
  logic                       pair_has1_q[$];
  logic [`REG_ADDR_WIDTH-1:0] case_reg[$];
  logic [`DATA_WIDTH-1:0]     case_data[$];

  // writebacks still owed by the running test
  logic [`REG_ADDR_WIDTH-1:0] exp_reg[$];
  logic [`DATA_WIDTH-1:0]     exp_data[$];

  int error_count = 0;
  int test_errors = 0;
  int wb_seen     = 0;
  int total_pairs = 0;
  bit loaded      = 1'b0;

  dual_pipe_core i_dual_pipe_core (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (req),
    .pair_has1 (pair_has1),
    .inst0     (inst0),
    .inst1     (inst1),
    .ack       (ack),
    .wb_valid0 (wb_valid0),
    .wb_valid1 (wb_valid1),
    .wb_reg0   (wb_reg0),
    .wb_reg1   (wb_reg1),
    .wb_data0  (wb_data0),
    .wb_data1  (wb_data1)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  ////////////////////////////////////////
  // compare tasks

  task automatic check_reg(input string name, input logic [`REG_ADDR_WIDTH-1:0] got,
                           input logic [`REG_ADDR_WIDTH-1:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
      error_count++;
      test_errors++;
    end
  endtask

  task automatic check_data(input string name, input logic [`DATA_WIDTH-1:0] got,
                            input logic [`DATA_WIDTH-1:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
      error_count++;
      test_errors++;
    end
  endtask

  task automatic check_latency(input int got, input int exp);
    if (got != exp) begin
      $display("CHECK FAILED ack latency: got %h cycles, expected %h", got, exp);
      error_count++;
      test_errors++;
    end
  endtask

  task automatic take_writeback(input int lane, input logic [`REG_ADDR_WIDTH-1:0] reg_addr,
                                input logic [`DATA_WIDTH-1:0] data);
    wb_seen++;
    if (exp_reg.size() == 0) begin
      $display("lane %0d wrote r%0d = %h although no writeback was expected",
               lane, reg_addr, data);
      error_count++;
      test_errors++;
    end else begin
      check_reg($sformatf("wb_reg%0d", lane), reg_addr, exp_reg.pop_front());
      check_data($sformatf("wb_data%0d", lane), data, exp_data.pop_front());
    end
  endtask

  // lane 0 holds the older instruction of a cycle
  always @(negedge clk) begin
    if (rst_n === 1'b1) begin
      if (wb_valid0 === 1'b1) begin
        take_writeback(0, wb_reg0, wb_data0);
      end
      if (wb_valid1 === 1'b1) begin
        take_writeback(1, wb_reg1, wb_data1);
      end
    end
  end

  ////////////////////////////////////////
  // case file and driver

  task automatic load_cases();
    int                         fd;
    int                         n;
    string                      line;
    string                      name;
    logic [`INST_WIDTH-1:0]     i0;
    logic [`INST_WIDTH-1:0]     i1;
    logic                       h;
    logic [`REG_ADDR_WIDTH-1:0] r;
    logic [`DATA_WIDTH-1:0]     d;
    fd = $fopen("verification/dual_pipe_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open the case file");
      error_count++;
      return;
    end
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if (n > 0 && line.len() > 0) begin
        if (line[0] == "T") begin
          n = $sscanf(line, "T %s", name);
          test_names.push_back(name);
          test_pair_count.push_back(0);
          test_wb_count.push_back(0);
        end else if (line[0] == "P") begin
          n = $sscanf(line, "P %h %h %h", i0, i1, h);
          pair_inst0.push_back(i0);
          pair_inst1.push_back(i1);
          pair_has1_q.push_back(h);
          test_pair_count[$] += 1;
        end else if (line[0] == "W") begin
          n = $sscanf(line, "W %h %h", r, d);
          case_reg.push_back(r);
          case_data.push_back(d);
          test_wb_count[$] += 1;
        end
      end
    end
    $fclose(fd);
    total_pairs = pair_inst0.size();
  endtask

  function automatic int count_insts(input logic [`INST_WIDTH-1:0] i0,
                                     input logic [`INST_WIDTH-1:0] i1, input logic has1);
    opcode_e op0;
    opcode_e op1;
    op0 = opcode_e'(i0[`OPCODE_MSB:`OPCODE_LSB]);
    op1 = opcode_e'(i1[`OPCODE_MSB:`OPCODE_LSB]);
    count_insts = int'(op0 != op_nop) + int'(has1 && (op1 != op_nop));
  endfunction

  // inst1 reads the nonzero register that inst0 writes
  function automatic bit splits_pair(input logic [`INST_WIDTH-1:0] i0,
                                     input logic [`INST_WIDTH-1:0] i1, input logic has1);
    opcode_e                    op0;
    opcode_e                    op1;
    logic [`REG_ADDR_WIDTH-1:0] dst;
    bit                         reg_form1;
    bit                         uses_rs1;
    op0 = opcode_e'(i0[`OPCODE_MSB:`OPCODE_LSB]);
    op1 = opcode_e'(i1[`OPCODE_MSB:`OPCODE_LSB]);
    if ((op0 == op_addi) || (op0 == op_ori)) begin
      dst = i0[`RT_MSB:`RT_LSB];
    end else if (op0 != op_nop) begin
      dst = i0[`RD_MSB:`RD_LSB];
    end else begin
      dst = '0;
    end
    reg_form1 = (op1 != op_nop) && (op1 != op_addi) && (op1 != op_ori);
    // sll takes only rt
    uses_rs1  = (op1 != op_nop) && (op1 != op_sll);
    splits_pair = has1 && (dst != '0) &&
                  ((uses_rs1 && (i1[`RS_MSB:`RS_LSB] == dst)) ||
                   (reg_form1 && (i1[`RT_MSB:`RT_LSB] == dst)));
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #drive_delay;
  endtask

  // four-phase transfer of one pair
  task automatic send_pair(input logic [`INST_WIDTH-1:0] i0, input logic [`INST_WIDTH-1:0] i1,
                           input logic has1);
    int unsigned gap;
    int          cycles;
    gap = $urandom % 4;
    repeat (gap) next_cycle();
    inst0     = i0;
    inst1     = i1;
    pair_has1 = has1;
    req       = 1'b1;
    cycles    = 0;
    do begin
      next_cycle();
      cycles++;
    end while (ack !== 1'b1);
    // a split pair holds ack back one more cycle
    check_latency(cycles, splits_pair(i0, i1, has1) ? 2 : 1);
    req = 1'b0;
    do next_cycle(); while (ack !== 1'b0);
  endtask

  ////////////////////////////////////////
  // main flow

  initial begin
    int pair_idx;
    int wb_idx;
    int n_inst;
    int t;
    int i;
    rst_n     = 1'b0;
    req       = 1'b0;
    pair_has1 = 1'b0;
    inst0     = '0;
    inst1     = '0;
    void'($urandom(32'h45d4_de03));
    load_cases();
    loaded = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    #drive_delay;
    rst_n    = 1'b1;
    pair_idx = 0;
    wb_idx   = 0;
    for (t = 0; t < test_names.size(); t++) begin
      test_errors = 0;
      wb_seen     = 0;
      n_inst      = 0;
      for (i = 0; i < test_wb_count[t]; i++) begin
        exp_reg.push_back(case_reg[wb_idx]);
        exp_data.push_back(case_data[wb_idx]);
        wb_idx++;
      end
      for (i = 0; i < test_pair_count[t]; i++) begin
        send_pair(pair_inst0[pair_idx], pair_inst1[pair_idx], pair_has1_q[pair_idx]);
        n_inst += count_insts(pair_inst0[pair_idx], pair_inst1[pair_idx],
                              pair_has1_q[pair_idx]);
        pair_idx++;
      end
      // last writeback lands two edges after its issue
      repeat (3) next_cycle();
      if (exp_reg.size() != 0) begin
        $display("test %s: %0d expected writebacks never arrived", test_names[t],
                 exp_reg.size());
        error_count++;
        test_errors++;
        exp_reg.delete();
        exp_data.delete();
      end
      $display("test %-18s %0d instructions, %0d writebacks, %0d mismatches",
               test_names[t], n_inst, wb_seen, test_errors);
    end
    error_count += i_dual_pipe_core.i_dual_pipe_checker.fail_count;
    $display("%0d tests, %0d pairs, %0d failed checks", test_names.size(), total_pairs,
             error_count);
    if (error_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // run length follows the size of the case file
  initial begin
    int limit;
    wait (loaded);
    limit = reset_cycles + total_pairs * 20 + test_names.size() * 10;
    repeat (limit) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles", limit);
    $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
+incdir+src
src/dual_pipe_pkg.sv
src/issue_unit.sv
src/decode_lane.sv
src/register_file.sv
src/execute_lane.sv
src/dual_pipe_core.sv
verification/dual_pipe_checker.sv
verification/dual_pipe_tb.sv

//--- verification/dual_pipe_cases.txt
# T name | P inst0 inst1 has1 (hex) | W reg data (hex)
# W lines give the expected writebacks of a test in program order
T independent_ops
P 20011234 2402f00f 1
W 01 00001234
W 02 0000f00f
P 20038000 2404ffff 1
W 03 00008000
W 04 0000ffff
P 08012800 04223000 1
W 05 ffffedcc
W 06 00010243
P 0c443800 10234000 1
W 07 0000f00f
W 08 00009234
P 14414800 18a15000 1
W 09 0000e23b
W 0a 00000001
P 18255800 1c026100 1
W 0b 00000000
W 0c 000f00f0
T back_to_back
P 200d0005 200e0007 1
W 0d 00000005
W 0e 00000007
P 05ae7800 09cd8000 1
W 0f 0000000c
W 10 00000002
P 1c0f9880 160fa000 1
W 13 00000030
W 14 0000000e
P 26750100 0a93b000 1
W 15 00000130
W 16 ffffffde
T split_pair
P 21f10010 06309000 1
W 11 0000001c
W 12 0000001e
P 124db800 1ad7c000 1
W 17 0000001f
W 18 00000001
P 20190003 1c19d200 1
W 19 00000003
W 1a 00000300
T same_dest
P 201c0011 241c0022 1
W 1c 00000011
W 1c 00000022
P 0780e800 239e0001 1
W 1d 00000022
W 1e 00000023
P 0bddf800 17adf800 1
W 1f 00000001
W 1f 00000027
P 07e00800 00000000 0
W 01 00000027
T r0_and_single
P 20000055 24020066 1
W 02 00000066
P 00000000 00000000 0
P 00000000 04401800 1
W 03 00000066
P 04430000 04022800 1
W 05 00000066
P 10022000 04a52000 0
W 04 00000066
